//--- src.f
+incdir+.
tetrisPkg.sv
pieceShape.sv
pieceMover.sv
boardStore.sv
gameStatus.sv
gameControl.sv
tbGameControl.sv

//--- Makefile
TOP = tbGameControl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Result: PASSED" > /dev/null

clean:
	rm -rf obj_dir

//--- tbBoardModel.svh
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// Col/row offset pairs per type and rotation
localparam int ShapeTab [5][4][8] = '{
    '{'{-2, 0, -1, 0, 0, 0, 1, 0}, '{0, -2, 0, -1, 0, 0, 0, 1},
      '{-2, 0, -1, 0, 0, 0, 1, 0}, '{0, -2, 0, -1, 0, 0, 0, 1}},
    '{'{0, 0, 1, 0, 0, -1, 1, -1}, '{0, 0, 1, 0, 0, -1, 1, -1},
      '{0, 0, 1, 0, 0, -1, 1, -1}, '{0, 0, 1, 0, 0, -1, 1, -1}},
    '{'{-1, 0, 0, 0, 1, 0, 0, -1}, '{0, -1, 0, 0, 0, 1, 1, 0},
      '{-1, 0, 0, 0, 1, 0, 0, 1}, '{0, -1, 0, 0, 0, 1, -1, 0}},
    '{'{-1, 0, 0, 0, 1, 0, 1, -1}, '{0, -1, 0, 0, 0, 1, 1, 1},
      '{-1, 0, 0, 0, 1, 0, -1, 1}, '{0, -1, 0, 0, 0, 1, -1, -1}},
    '{'{-1, 0, 0, 0, 0, -1, 1, -1}, '{0, 0, -1, 0, -1, -1, 0, 1},
      '{0, 0, 1, 0, -1, -1, 0, -1}, '{0, 0, -1, 0, 0, -1, -1, 1}}
};

logic [TotalRows-1:0][BoardCols-1:0] mBoard;
int mType;
int mRot;
int mCol;
int mRow;
int mNext;
int mScore;
bit mFail;

function automatic void mReset();
    mBoard = '0;
    mType  = 0;
    mRot   = 0;
    mCol   = SpawnCol;
    mRow   = SpawnRow;
    mNext  = 1;
    mScore = 0;
    mFail  = 1'b0;
endfunction

function automatic bit mBlocked(int rot, int col, int row);
    int c;
    int r;
    mBlocked = 1'b0;
    for (int k = 0; k < 4; k++) begin
        c = col + ShapeTab[mType][rot][2 * k];
        r = row + ShapeTab[mType][rot][2 * k + 1];
        if (c < 0 || c >= BoardCols || r < 0 || r >= TotalRows)
            mBlocked = 1'b1;
        else if (mBoard[r][c])
            mBlocked = 1'b1;
    end
endfunction

function automatic void mKey(logic [1:0] key);
    int nRot;
    int nCol;
    nRot = (key == KeyRotate) ? (mRot + 1) % 4 : mRot;
    nCol = mCol + ((key == KeyRight) ? 1 : 0) - ((key == KeyLeft) ? 1 : 0);
    if (mFail || key == KeyIdle)
        return;
    if (!mBlocked(nRot, nCol, mRow)) begin
        mRot = nRot;
        mCol = nCol;
    end
endfunction

// Lock, compact the visible rows, then score and respawn
function automatic void mLock();
    logic [TotalRows-1:0][BoardCols-1:0] nb;
    int n;
    int w;
    int r;
    for (int k = 0; k < 4; k++) begin
        r = mRow + ShapeTab[mType][mRot][2 * k + 1];
        mBoard[r][mCol + ShapeTab[mType][mRot][2 * k]] = 1'b1;
        if (r < HiddenRows)
            mFail = 1'b1;
    end
    nb = mBoard;
    n  = 0;
    w  = TotalRows - 1;
    for (int i = TotalRows - 1; i >= HiddenRows; i--) begin
        if (&mBoard[i]) begin
            n++;
        end else begin
            nb[w] = mBoard[i];
            w--;
        end
    end
    for (int i = w; i >= HiddenRows; i--)
        nb[i] = '0;
    mBoard = nb;
    if (!mFail) begin
        mScore = (mScore + LandScore + RowScore * n) % 128;
        mType  = mNext;
        mNext  = (mNext + 1) % NumPieces;
        mRot   = 0;
        mCol   = SpawnCol;
        mRow   = SpawnRow;
    end
endfunction

function automatic void mTick();
    if (mFail)
        return;
    if (!mBlocked(mRot, mCol, mRow + 1))
        mRow++;
    else
        mLock();
endfunction

function automatic logic [ObjectBits-1:0] mObjects();
    logic [ObjectBits-1:0] o;
    int c;
    int r;
    o = mBoard[TotalRows-1:HiddenRows];
    for (int k = 0; k < 4; k++) begin
        c = mCol + ShapeTab[mType][mRot][2 * k];
        r = mRow + ShapeTab[mType][mRot][2 * k + 1];
        if (r >= HiddenRows)
            o[(r - HiddenRows) * BoardCols + c] = 1'b1;
    end
    return o;
endfunction

`endif

//--- tbGameControl.sv
`timescale 1ns/1ps

module tbGameControl
    import tetrisPkg::*;
();

    localparam int ActTick      = 4;
    localparam int SettleCycles = 30;

    logic                  clk;
    logic                  rstReg;
    logic [1:0]            keyCode;
    logic                  dropTick;
    logic [6:0]            score;
    logic [2:0]            nextBlock;
    logic [ObjectBits-1:0] objects;
    logic                  fail;

    // Stimulus table, one entry per step
    int    stepAct[$];
    int    stepReps[$];
    bit    stepHold[$];
    bit    stepChk[$];
    string stepName[$];

    int cycleCount = 0;
    int cycleLimit = 0;
    int passCount  = 0;
    int failCount  = 0;

`include "tbBoardModel.svh"

    gameControl i_gameControl (
        .clk       (clk),
        .rstReg    (rstReg),
        .keyCode   (keyCode),
        .dropTick  (dropTick),
        .score     (score),
        .nextBlock (nextBlock),
        .objects   (objects),
        .fail      (fail)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic addStep(input int act, input int reps, input bit hold, input bit chk,
                           input string name);
        stepAct.push_back(act);
        stepReps.push_back(reps);
        stepHold.push_back(hold);
        stepChk.push_back(chk);
        stepName.push_back(name);
    endtask

    // ####################################################################
    // Stimulus table
    // ####################################################################

    task automatic buildTable();
        addStep(KeyIdle,   1,   0, 1, "after reset");
        addStep(ActTick,   3,   0, 1, "gravity into visible row 1");
        addStep(ActTick,   2,   0, 1, "gravity two more rows");
        addStep(KeyLeft,   5,   0, 1, "left wall");
        addStep(KeyRight,  8,   0, 1, "right wall");
        addStep(KeyLeft,   10,  1, 1, "held key moves once");
        addStep(KeyRotate, 1,   0, 1, "bar turns vertical");
        addStep(KeyRight,  2,   0, 1, "vertical bar at right edge");
        addStep(KeyRotate, 1,   0, 1, "rotation blocked by wall");
        addStep(KeyLeft,   7,   0, 0, "");
        addStep(KeyRotate, 1,   0, 1, "bar horizontal at left");
        addStep(ActTick,   17,  0, 1, "bar lands on floor");
        // Square, T and L fill the bottom row
        addStep(KeyLeft,   1,   0, 0, "");
        addStep(ActTick,   22,  0, 1, "square lands");
        addStep(KeyRight,  2,   0, 0, "");
        addStep(ActTick,   22,  0, 1, "T lands");
        addStep(KeyRotate, 3,   0, 0, "");
        addStep(KeyRight,  5,   0, 0, "");
        addStep(ActTick,   21,  0, 1, "L completes bottom row");
        addStep(ActTick,   21,  0, 1, "S lands on settled cells");
        addStep(ActTick,   18,  0, 0, "");
        addStep(KeyRotate, 1,   0, 1, "rotation blocked by settled cell");
        // Stack at the centre until a lock reaches the hidden rows
        addStep(ActTick,   300, 0, 1, "stack reaches hidden rows");
        addStep(KeyLeft,   2,   0, 0, "");
        addStep(KeyRight,  1,   0, 0, "");
        addStep(KeyRotate, 1,   0, 0, "");
        addStep(ActTick,   5,   0, 1, "inputs ignored after fail");
    endtask

    task automatic settle();
        int gap;
        gap = $urandom % 2;
        repeat (SettleCycles + gap) @(negedge clk);
    endtask

    // Starts and ends on a falling edge
    task automatic runStep(input int idx);
        int         act;
        int         reps;
        logic [1:0] key;
        act  = stepAct[idx];
        reps = stepReps[idx];
        key  = 2'(act);
        if (stepHold[idx]) begin
            keyCode = key;
            repeat (reps) @(negedge clk);
            keyCode = KeyIdle;
            mKey(key);
            settle();
        end else begin
            for (int n = 0; n < reps; n++) begin
                if (act == ActTick) begin
                    dropTick = 1'b1;
                end else begin
                    keyCode = key;
                end
                @(negedge clk);
                dropTick = 1'b0;
                keyCode  = KeyIdle;
                if (act == ActTick) begin
                    mTick();
                end else begin
                    mKey(key);
                end
                settle();
            end
        end
    endtask

    task automatic checkOutputs(output int errs);
        logic [ObjectBits-1:0] expObj;
        expObj = mObjects();
        errs   = 0;
        if (objects !== expObj) begin
            $display("** Error at %0t: objects expected %h, got %h", $time, expObj, objects);
            errs++;
        end
        if (score !== 7'(mScore)) begin
            $display("** Error at %0t: score expected %0d, got %0d", $time, mScore, score);
            errs++;
        end
        if (nextBlock !== 3'(mNext)) begin
            $display("** Error at %0t: nextBlock expected %0d, got %0d",
                     $time, mNext, nextBlock);
            errs++;
        end
        if (fail !== mFail) begin
            $display("** Error at %0t: fail expected %0b, got %0b", $time, mFail, fail);
            errs++;
        end
    endtask

    // ####################################################################
    // Main sequence
    // ####################################################################

    initial begin
        int total;
        int errs;
        int testNum;
        void'($urandom(32'hb171));
        rstReg   = 1'b1;
        keyCode  = KeyIdle;
        dropTick = 1'b0;
        buildTable();
        total = 0;
        foreach (stepReps[i]) begin
            total += stepReps[i];
        end
        cycleLimit = total * 32 + 200;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstReg = 1'b0;
        mReset();

        for (int i = 0; i < stepAct.size(); i++) begin
            runStep(i);
            if (stepChk[i]) begin
                testNum = passCount + failCount + 1;
                checkOutputs(errs);
                if (errs == 0) begin
                    passCount++;
                    $display("Test %0d (%s): passed", testNum, stepName[i]);
                end else begin
                    failCount++;
                    $display("Test %0d (%s): %0d mismatches", testNum, stepName[i], errs);
                end
            end
        end

        if (!mFail) begin
            $display("The stacking steps never pushed a piece into the hidden rows");
            failCount++;
        end

        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cycleLimit > 0);
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycleLimit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- gameControl.sv
`timescale 1ns/1ps

module gameControl
    import tetrisPkg::*;
(
    input  logic                  clk,
    input  logic                  rstReg,
    input  logic [1:0]            keyCode,
    input  logic                  dropTick,
    output logic [6:0]            score,
    output logic [2:0]            nextBlock,
    output logic [ObjectBits-1:0] objects,
    output logic                  fail
);

    logic [2:0]              pieceType;
    logic [1:0]              rotation;
    logic [ColBits-1:0]      centerCol;
    logic [RowBits-1:0]      centerRow;
    logic [1:0]              candRotation;
    logic [ColBits-1:0]      candCol;
    logic [RowBits-1:0]      candRow;
    logic [3:0][ColBits-1:0] curCols;
    logic [3:0][RowBits-1:0] curRows;
    logic [3:0][ColBits-1:0] candCols;
    logic [3:0][RowBits-1:0] candRows;
    logic                    blocked;
    logic                    busy;
    logic                    clearDone;
    logic [2:0]              rowsCleared;
    logic [ObjectBits-1:0]   settled;
    logic                    lockPiece;

    pieceShape curShape (
        .pieceType (pieceType),
        .rotation  (rotation),
        .centerCol (centerCol),
        .centerRow (centerRow),
        .cellCols  (curCols),
        .cellRows  (curRows)
    );

    pieceShape candShape (
        .pieceType (pieceType),
        .rotation  (candRotation),
        .centerCol (candCol),
        .centerRow (candRow),
        .cellCols  (candCols),
        .cellRows  (candRows)
    );

    boardStore store (
        .clk         (clk),
        .rstReg      (rstReg),
        .candCols    (candCols),
        .candRows    (candRows),
        .curCols     (curCols),
        .curRows     (curRows),
        .lockPiece   (lockPiece),
        .blocked     (blocked),
        .busy        (busy),
        .clearDone   (clearDone),
        .rowsCleared (rowsCleared),
        .settled     (settled)
    );

    pieceMover mover (
        .clk          (clk),
        .rstReg       (rstReg),
        .keyCode      (keyCode),
        .dropTick     (dropTick),
        .blocked      (blocked),
        .busy         (busy),
        .clearDone    (clearDone),
        .nextBlock    (nextBlock),
        .fail         (fail),
        .pieceType    (pieceType),
        .rotation     (rotation),
        .centerCol    (centerCol),
        .centerRow    (centerRow),
        .candRotation (candRotation),
        .candCol      (candCol),
        .candRow      (candRow),
        .lockPiece    (lockPiece)
    );

    gameStatus status (
        .clk         (clk),
        .rstReg      (rstReg),
        .lockPiece   (lockPiece),
        .curRows     (curRows),
        .clearDone   (clearDone),
        .rowsCleared (rowsCleared),
        .score       (score),
        .nextBlock   (nextBlock),
        .fail        (fail)
    );

    // Active piece drawn over the settled cells, visible rows only
    always_comb begin
        logic [7:0] bitIdx;
        objects = settled;
        for (int i = 0; i < 4; i++) begin
            bitIdx = 8'((curRows[i] - HiddenRows) * BoardCols + curCols[i]);
            if (curRows[i] >= HiddenRows && curRows[i] < TotalRows &&
                curCols[i] < BoardCols) begin
                objects[bitIdx] = 1'b1;
            end
        end
    end

endmodule

//--- gameStatus.sv
`timescale 1ns/1ps

module gameStatus
    import tetrisPkg::*;
(
    input  logic                    clk,
    input  logic                    rstReg,
    input  logic                    lockPiece,
    input  logic [3:0][RowBits-1:0] curRows,
    input  logic                    clearDone,
    input  logic [2:0]              rowsCleared,
    output logic [6:0]              score,
    output logic [2:0]              nextBlock,
    output logic                    fail
);

    logic lockHigh;

    // Any cell still in the hidden rows
    always_comb begin
        lockHigh = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (curRows[i] < HiddenRows) begin
                lockHigh = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rstReg) begin
            score     <= '0;
            nextBlock <= 3'd1;
            fail      <= 1'b0;
        end else begin
            if (lockPiece && lockHigh) begin
                fail <= 1'b1;
            end
            if (clearDone && !fail) begin
                score     <= score + LandScore + RowScore * 7'(rowsCleared);
                nextBlock <= (nextBlock == 3'(NumPieces - 1)) ? 3'd0 : nextBlock + 3'd1;
            end
        end
    end

endmodule

//--- boardStore.sv
`timescale 1ns/1ps

module boardStore
    import tetrisPkg::*;
(
    input  logic                    clk,
    input  logic                    rstReg,
    input  logic [3:0][ColBits-1:0] candCols,
    input  logic [3:0][RowBits-1:0] candRows,
    input  logic [3:0][ColBits-1:0] curCols,
    input  logic [3:0][RowBits-1:0] curRows,
    input  logic                    lockPiece,
    output logic                    blocked,
    output logic                    busy,
    output logic                    clearDone,
    output logic [2:0]              rowsCleared,
    output logic [ObjectBits-1:0]   settled
);

    // Settled cells only, row 0 is the top hidden row
    logic [TotalRows-1:0][BoardCols-1:0] board;

    logic [RowBits-1:0] readPtr;
    logic [RowBits-1:0] writePtr;
    logic [2:0]         skipCount;
    logic               rowFull;

    // ####################################################################
    // Collision lookup
    // ####################################################################

    always_comb begin
        blocked = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (candCols[i] >= BoardCols || candRows[i] >= TotalRows) begin
                blocked = 1'b1;
            end else if (board[candRows[i]][candCols[i][3:0]]) begin
                blocked = 1'b1;
            end
        end
    end

    // ####################################################################
    // Lock and bottom-up compaction, one row per cycle
    // ####################################################################

    assign rowFull     = &board[readPtr];
    assign clearDone   = busy && (readPtr == RowBits'(HiddenRows));
    assign rowsCleared = skipCount + {2'b00, rowFull};
    assign settled     = board[TotalRows-1:HiddenRows];

    always_ff @(posedge clk) begin
        if (rstReg) begin
            board     <= '0;
            busy      <= 1'b0;
            readPtr   <= '0;
            writePtr  <= '0;
            skipCount <= '0;
        end else if (lockPiece) begin
            for (int i = 0; i < 4; i++) begin
                board[curRows[i]][curCols[i][3:0]] <= 1'b1;
            end
            busy      <= 1'b1;
            readPtr   <= RowBits'(TotalRows - 1);
            writePtr  <= RowBits'(TotalRows - 1);
            skipCount <= '0;
        end else if (busy) begin
            if (rowFull) begin
                board[readPtr] <= '0;
                skipCount      <= skipCount + 1'b1;
            end else begin
                // Source row is emptied, a later copy may refill it
                if (writePtr != readPtr) begin
                    board[readPtr]  <= '0;
                    board[writePtr] <= board[readPtr];
                end
                writePtr <= writePtr - 1'b1;
            end
            readPtr <= readPtr - 1'b1;
            if (clearDone) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- pieceMover.sv
`timescale 1ns/1ps

module pieceMover
    import tetrisPkg::*;
(
    input  logic               clk,
    input  logic               rstReg,
    input  logic [1:0]         keyCode,
    input  logic               dropTick,
    input  logic               blocked,
    input  logic               busy,
    input  logic               clearDone,
    input  logic [2:0]         nextBlock,
    input  logic               fail,
    output logic [2:0]         pieceType,
    output logic [1:0]         rotation,
    output logic [ColBits-1:0] centerCol,
    output logic [RowBits-1:0] centerRow,
    output logic [1:0]         candRotation,
    output logic [ColBits-1:0] candCol,
    output logic [RowBits-1:0] candRow,
    output logic               lockPiece
);

    logic lastIdle;
    logic keyPress;
    logic active;
    logic moveOk;

    assign active = !busy && !fail;

    // One action per press, held keys repeat nothing
    assign keyPress = lastIdle && (keyCode != KeyIdle);

    assign lockPiece = active && dropTick && blocked;
    assign moveOk    = active && (dropTick || keyPress) && !blocked;

    always_ff @(posedge clk) begin
        if (rstReg) begin
            lastIdle <= 1'b1;
        end else begin
            lastIdle <= (keyCode == KeyIdle);
        end
    end

    // ####################################################################
    // Candidate position, gravity has priority over keys
    // ####################################################################

    always_comb begin
        candRotation = rotation;
        candCol      = centerCol;
        candRow      = centerRow;
        if (dropTick) begin
            candRow = centerRow + 1'b1;
        end else if (keyPress) begin
            case (keyCode)
                KeyLeft:   candCol = centerCol - 1'b1;
                KeyRight:  candCol = centerCol + 1'b1;
                KeyRotate: candRotation = rotation + 1'b1;
                default:   candRotation = rotation;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rstReg) begin
            pieceType <= 3'd0;
            rotation  <= 2'd0;
            centerCol <= ColBits'(SpawnCol);
            centerRow <= RowBits'(SpawnRow);
        end else if (clearDone && !fail) begin
            // Respawn once the board scan is over
            pieceType <= nextBlock;
            rotation  <= 2'd0;
            centerCol <= ColBits'(SpawnCol);
            centerRow <= RowBits'(SpawnRow);
        end else if (moveOk) begin
            rotation  <= candRotation;
            centerCol <= candCol;
            centerRow <= candRow;
        end
    end

endmodule

//--- pieceShape.sv
`timescale 1ns/1ps

module pieceShape
    import tetrisPkg::*;
(
    input  logic [2:0]              pieceType,
    input  logic [1:0]              rotation,
    input  logic [ColBits-1:0]      centerCol,
    input  logic [RowBits-1:0]      centerRow,
    output logic [3:0][ColBits-1:0] cellCols,
    output logic [3:0][RowBits-1:0] cellRows
);

    // Col/row offset pairs, one pair per cell
    logic [7:0][ColBits-1:0] offs;

    always_comb begin
        case ({pieceType, rotation})
            // Bar
            5'b000_00, 5'b000_10: offs = {-5'd2, 5'd0, -5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd0};
            5'b000_01, 5'b000_11: offs = {5'd0, -5'd2, 5'd0, -5'd1, 5'd0, 5'd0, 5'd0, 5'd1};

            // Square, same in every rotation
            5'b001_00, 5'b001_01, 5'b001_10, 5'b001_11:
                offs = {5'd0, 5'd0, 5'd1, 5'd0, 5'd0, -5'd1, 5'd1, -5'd1};

            // T
            5'b010_00: offs = {-5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd0, 5'd0, -5'd1};
            5'b010_01: offs = {5'd0, -5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd1, 5'd0};
            5'b010_10: offs = {-5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd0, 5'd0, 5'd1};
            5'b010_11: offs = {5'd0, -5'd1, 5'd0, 5'd0, 5'd0, 5'd1, -5'd1, 5'd0};

            // L
            5'b011_00: offs = {-5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd0, 5'd1, -5'd1};
            5'b011_01: offs = {5'd0, -5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd1, 5'd1};
            5'b011_10: offs = {-5'd1, 5'd0, 5'd0, 5'd0, 5'd1, 5'd0, -5'd1, 5'd1};
            5'b011_11: offs = {5'd0, -5'd1, 5'd0, 5'd0, 5'd0, 5'd1, -5'd1, -5'd1};

            // S
            5'b100_00: offs = {-5'd1, 5'd0, 5'd0, 5'd0, 5'd0, -5'd1, 5'd1, -5'd1};
            5'b100_01: offs = {5'd0, 5'd0, -5'd1, 5'd0, -5'd1, -5'd1, 5'd0, 5'd1};
            5'b100_10: offs = {5'd0, 5'd0, 5'd1, 5'd0, -5'd1, -5'd1, 5'd0, -5'd1};
            5'b100_11: offs = {5'd0, 5'd0, -5'd1, 5'd0, 5'd0, -5'd1, -5'd1, 5'd1};

            default: offs = '0;
        endcase
    end

    // Offsets wrap modulo 32, so cells past the left wall land at 29..31
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cellCols[i] = centerCol + offs[2 * i + 1];
            cellRows[i] = centerRow + offs[2 * i];
        end
    end

endmodule

//--- tetrisPkg.sv
package tetrisPkg;

    // Board geometry
    localparam int BoardCols   = 10;
    localparam int VisibleRows = 20;
    localparam int HiddenRows  = 4;
    localparam int TotalRows   = VisibleRows + HiddenRows;
    localparam int ObjectBits  = VisibleRows * BoardCols;

    localparam int NumPieces   = 5;

    // Index widths, columns keep room for negative offsets
    localparam int RowBits     = 5;
    localparam int ColBits     = 5;

    // Spawn centre in board coordinates
    localparam int SpawnCol    = 5;
    localparam int SpawnRow    = 2;

    // Key codes
    localparam logic [1:0] KeyIdle   = 2'd0;
    localparam logic [1:0] KeyLeft   = 2'd1;
    localparam logic [1:0] KeyRight  = 2'd2;
    localparam logic [1:0] KeyRotate = 2'd3;

    // Scoring
    localparam logic [6:0] LandScore = 7'd1;
    localparam logic [6:0] RowScore  = 7'd10;

endpackage
